// File: icache_assertions.sv
`timescale 1ns/100ps
module icache_assertions import icache_pkg::*; (
    input logic              clk,
    input logic              arst_n,
    input logic              req_valid,
    input logic              req_ready,
    input icache_req_t       req,
    input logic              resp_valid,
    input logic              resp_ready,
    input icache_resp_t      resp,
    input logic              ar_valid,
    input logic              ar_ready,
    input logic [addr_w-1:0] ar_addr,
    input logic              r_ready
);

    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("request changed while stalled");

    resp_held: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response changed before resp_ready");

    ar_held: assert property (@(posedge clk) disable iff (!arst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("ar_addr changed before ar_ready");

    // misaligned fetch never reaches the bus
    align_no_bus: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && (resp.exc == exc_align) |-> !ar_valid && !r_ready)
        else $error("bus active during an alignment exception");

    reset_state: assert property (@(posedge clk)
        !arst_n |-> req_ready && !resp_valid && !ar_valid && !r_ready)
        else $error("outputs not in reset state");

endmodule

bind icache_top icache_assertions i_assertions (.*);

// File: icache_ctrl.sv
`timescale 1ns/100ps
module icache_ctrl import icache_pkg::*; (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  icache_req_t                 req,
    output logic                        resp_valid,
    input  logic                        resp_ready,
    output icache_resp_t                resp,
    input  logic                        hit,
    input  logic [ways-1:0]             hit_way,
    input  logic [ways-1:0][data_w-1:0] rd_data,
    input  logic [ways-1:0]             victim,
    output logic [index_w-1:0]          rd_index,
    output logic [tag_w-1:0]            rd_tag,
    output logic [1:0]                  rd_word,
    output logic [ways-1:0]             data_we,
    output logic [index_w-1:0]          wr_index,
    output logic [1:0]                  wr_word,
    output logic [data_w-1:0]           wr_data,
    output logic [ways-1:0]             tag_we,
    output icache_tag_t                 wr_entry,
    output logic                        set_inval,
    output logic                        lru_touch,
    output logic [ways-1:0]             touch_way,
    output logic                        refill_start,
    output logic [addr_w-1:0]           refill_addr,
    output logic                        refill_line,
    input  logic                        word_valid,
    input  logic [data_w-1:0]           word_data,
    input  logic [1:0]                  word_idx,
    input  logic                        word_err,
    input  logic                        refill_done,
    input  logic                        refill_err
);

    icache_state_e     state_q;
    icache_req_t       req_q;       // request buffer
    icache_resp_t      resp_q;
    logic [ways-1:0]   victim_q;
    logic [addr_w-1:0] look_addr;
    logic              is_fetch;
    logic              uncached;
    logic              misaligned;
    logic              lookup;
    logic              cached_miss;
    logic              fill_ok;
    logic [data_w-1:0] hit_data;

    // arrays see the incoming address while idle, the buffered one after
    assign look_addr = (state_q == st_idle) ? req.addr : req_q.addr;
    assign rd_index  = look_addr[offset_w +: index_w];
    assign rd_tag    = look_addr[addr_w-1 -: tag_w];
    assign rd_word   = look_addr[offset_w-1:2];

    assign is_fetch    = (req_q.op != op_inval_index);
    assign uncached    = (req_q.op == op_fetch_uncached);
    assign misaligned  = is_fetch && (req_q.addr[1:0] != 2'b00);
    assign lookup      = (state_q == st_lookup);
    assign cached_miss = lookup && is_fetch && !uncached && !misaligned && !hit;
    assign fill_ok     = (state_q == st_refill) && refill_done && !refill_err;

    always_comb begin
        hit_data = '0;
        for (int w = 0; w < ways; w++) begin
            if (hit_way[w]) begin
                hit_data = hit_data | rd_data[w];
            end
        end
    end

    assign req_ready  = (state_q == st_idle);
    assign resp_valid = (state_q == st_resp);
    assign resp       = resp_q;

    assign refill_start = lookup && is_fetch && !misaligned && (uncached || !hit);
    assign refill_addr  = req_q.addr;
    assign refill_line  = !uncached;

    assign wr_index = req_q.addr[offset_w +: index_w];
    assign wr_word  = word_idx;
    assign wr_data  = word_data;
    assign data_we  = ((state_q == st_refill) && word_valid) ? victim_q : '0;
    // victim goes invalid before its data is overwritten
    assign tag_we   = cached_miss ? victim : (fill_ok ? victim_q : '0);
    assign wr_entry = '{valid: (state_q == st_refill), tag: req_q.addr[addr_w-1 -: tag_w]};

    assign set_inval = lookup && (req_q.op == op_inval_index);
    assign lru_touch = (lookup && is_fetch && !uncached && !misaligned && hit) || fill_ok;
    assign touch_way = lookup ? hit_way : victim_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: if (req_valid) state_q <= st_lookup;
                st_lookup: begin
                    if (misaligned || !is_fetch) begin
                        state_q <= st_resp;
                    end else if (uncached) begin
                        state_q <= st_uncached;
                    end else begin
                        state_q <= hit ? st_resp : st_refill;
                    end
                end
                st_refill, st_uncached: if (refill_done) state_q <= st_resp;
                st_resp: if (resp_ready) state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && req_valid) begin
            req_q <= req;
        end
        if (cached_miss) begin
            victim_q <= victim;
        end
        case (state_q)
            st_lookup: begin
                if (misaligned) begin
                    resp_q <= '{data: '0, exc: exc_align};
                end else if (!is_fetch) begin
                    resp_q <= '{data: '0, exc: exc_none};
                end else begin
                    resp_q <= '{data: hit_data, exc: exc_none};   // replaced on a miss
                end
            end
            st_refill: begin
                if (word_valid && (word_idx == req_q.addr[offset_w-1:2])) begin
                    resp_q.data <= word_data;   // requested word out of the line
                end
                if (refill_done) begin
                    resp_q.exc <= refill_err ? exc_bus : exc_none;
                end
            end
            st_uncached: begin
                if (word_valid) begin
                    resp_q <= '{data: word_data, exc: word_err ? exc_bus : exc_none};
                end
            end
            default: ;
        endcase
    end

endmodule

// File: icache_data_array.sv
`timescale 1ns/100ps
module icache_data_array import icache_pkg::*; (
    input  logic                       clk,
    input  logic [index_w-1:0]         rd_index,
    input  logic [1:0]                 rd_word,
    input  logic [ways-1:0]            data_we,
    input  logic [index_w-1:0]         wr_index,
    input  logic [1:0]                 wr_word,
    input  logic [data_w-1:0]          wr_data,
    output logic [ways-1:0][data_w-1:0] rd_data
);

    // one word per way, set and word slot
    logic [data_w-1:0] data_mem [ways][sets][words_per_line];

    always_ff @(posedge clk) begin
        for (int w = 0; w < ways; w++) begin
            if (data_we[w]) begin
                data_mem[w][wr_index][wr_word] <= wr_data;   // one refill beat
            end
            rd_data[w] <= data_mem[w][rd_index][rd_word];    // both ways read together
        end
    end

endmodule

// File: icache_lru.sv
`timescale 1ns/100ps
module icache_lru import icache_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [index_w-1:0] index,
    input  logic               touch,
    input  logic [ways-1:0]    touch_way,
    output logic [ways-1:0]    victim
);

    // bit set means way 0 was used last, so way 1 goes next
    logic [sets-1:0] lru_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;                        // way 0 is the first victim
        end else if (touch) begin
            lru_q[index] <= touch_way[0];
        end
    end

    assign victim = lru_q[index] ? 2'b10 : 2'b01;   // one-hot

endmodule

// File: icache_patterns.txt
// op addr key expected_data expected_exc ar_count_delta  (hex, op ff ends the list)
// op 0 fetch 1 uncached 2 index invalidate, exc 0 none 1 align 2 bus
// miss then hit in one line
0 00001000 11111111 11110111 0 4
0 00001008 11111111 11110119 0 0
// key changes but the line stays stale until its set is invalidated
0 00001004 22222222 11110115 0 0
2 00001000 22222222 00000000 0 0
0 00001004 22222222 22223226 0 4
// tags A B C in set 3
0 00002030 00ab0000 00ab2030 0 4
0 00002230 00ab0000 00ab2230 0 4
0 00002034 00ab0000 00ab2034 0 0
0 00002430 00ab0000 00ab2430 0 4
0 00002038 00ab0000 00ab2038 0 0
0 0000223c 00ab0000 00ab223c 0 4
// uncached fetches bypass the arrays
1 00003000 00cd0000 00cd3000 0 1
0 00003000 00cd0000 00cd3000 0 4
1 00003004 00ee0000 00ee3004 0 1
0 00003004 00ee0000 00cd3004 0 0
// misaligned, then the SLVERR window 8000 to 80ff with zero data
0 00001002 00000000 00000000 1 0
1 00001001 00000000 00000000 1 0
0 00008010 00000000 00000000 2 4
0 00008014 00000000 00000000 2 4
1 00008020 00000000 00000000 2 1
// earlier lines still cached
0 00001008 44444444 2222322a 0 0
0 0000300c 00ee0000 00cd300c 0 0
ff 00000000 00000000 00000000 0 0

// File: icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int addr_w         = 32;
    localparam int data_w         = 32;
    localparam int ways           = 2;
    localparam int words_per_line = 4;
    localparam int offset_w       = 4;                          // 16-byte line
    localparam int index_w        = 5;
    localparam int tag_w          = addr_w - index_w - offset_w; // 23
    localparam int sets           = 1 << index_w;                // 32

    // requested operation
    typedef enum logic [1:0] {
        op_fetch          = 2'd0,
        op_fetch_uncached = 2'd1,
        op_inval_index    = 2'd2
    } icache_op_e;

    // exception code returned with each response
    typedef enum logic [1:0] {
        exc_none  = 2'd0,
        exc_align = 2'd1,
        exc_bus   = 2'd2
    } icache_exc_e;

    // main control FSM
    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_lookup   = 3'd1,
        st_refill   = 3'd2,
        st_uncached = 3'd3,
        st_resp     = 3'd4
    } icache_state_e;

    typedef struct packed {
        icache_op_e        op;
        logic [addr_w-1:0] addr;
    } icache_req_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        icache_exc_e       exc;
    } icache_resp_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } icache_tag_t;

endpackage

// File: icache_refill.sv
`timescale 1ns/100ps
module icache_refill import icache_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              refill_start,
    input  logic [addr_w-1:0] refill_addr,
    input  logic              refill_line,
    output logic              word_valid,
    output logic [data_w-1:0] word_data,
    output logic [1:0]        word_idx,
    output logic              word_err,
    output logic              refill_done,
    output logic              refill_err,
    output logic              ar_valid,
    input  logic              ar_ready,
    output logic [addr_w-1:0] ar_addr,
    output logic [2:0]        ar_prot,
    input  logic              r_valid,
    output logic              r_ready,
    input  logic [data_w-1:0] r_data,
    input  logic [1:0]        r_resp
);

    logic [addr_w-offset_w-1:0] line_q;     // line number of the refill
    logic                       multi_q;    // four beats instead of one
    logic [1:0]                 beat_q;
    logic                       err_q;
    logic                       last_beat;

    assign last_beat = !multi_q || (beat_q == 2'(words_per_line - 1));
    assign ar_addr   = {line_q, beat_q, 2'b00};
    assign ar_prot   = 3'b100;                  // instruction access

    // R beat is reported in its handshake cycle
    assign word_valid  = r_valid && r_ready;
    assign word_data   = r_data;
    assign word_idx    = beat_q;
    assign word_err    = (r_resp != 2'b00);
    assign refill_done = word_valid && last_beat;
    assign refill_err  = err_q || (word_valid && word_err);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
            beat_q   <= '0;
            err_q    <= 1'b0;
        end else if (refill_start) begin
            ar_valid <= 1'b1;
            beat_q   <= refill_line ? 2'b00 : refill_addr[offset_w-1:2];
            err_q    <= 1'b0;
        end else begin
            if (ar_valid && ar_ready) begin
                ar_valid <= 1'b0;
                r_ready  <= 1'b1;               // wait for the single beat
            end
            if (word_valid) begin
                r_ready <= 1'b0;
                err_q   <= refill_err;
                if (!last_beat) begin
                    beat_q   <= beat_q + 2'd1;
                    ar_valid <= 1'b1;           // next word of the line
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start) begin
            line_q  <= refill_addr[addr_w-1:offset_w];
            multi_q <= refill_line;
        end
    end

endmodule

// File: icache_tag_array.sv
`timescale 1ns/100ps
module icache_tag_array import icache_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [index_w-1:0] rd_index,
    input  logic [tag_w-1:0]   rd_tag,
    input  logic [ways-1:0]    tag_we,
    input  logic [index_w-1:0] wr_index,
    input  icache_tag_t        wr_entry,
    input  logic               set_inval,
    output logic [ways-1:0]    hit_way,
    output logic               hit
);

    logic [tag_w-1:0]               tag_mem [ways][sets];
    logic [ways-1:0][sets-1:0]      valid_q;
    logic [ways-1:0]                rd_valid_q;
    logic [ways-1:0][tag_w-1:0]     rd_tags_q;
    logic [tag_w-1:0]               rd_tag_q;   // compare tag, aligned with the read

    // valid bits and their read copy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= '0;
            rd_valid_q <= '0;
        end else begin
            for (int w = 0; w < ways; w++) begin
                rd_valid_q[w] <= valid_q[w][rd_index];
                if (set_inval) begin
                    valid_q[w][wr_index] <= 1'b0;   // whole set
                end else if (tag_we[w]) begin
                    valid_q[w][wr_index] <= wr_entry.valid;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_tag_q <= rd_tag;
        for (int w = 0; w < ways; w++) begin
            rd_tags_q[w] <= tag_mem[w][rd_index];
            if (tag_we[w]) begin
                tag_mem[w][wr_index] <= wr_entry.tag;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            hit_way[w] = rd_valid_q[w] && (rd_tags_q[w] == rd_tag_q);
        end
    end

    assign hit = |hit_way;

endmodule

// File: icache_top.sv
`timescale 1ns/100ps
module icache_top import icache_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  icache_req_t       req,
    output logic              resp_valid,
    input  logic              resp_ready,
    output icache_resp_t      resp,
    output logic              ar_valid,
    input  logic              ar_ready,
    output logic [addr_w-1:0] ar_addr,
    output logic [2:0]        ar_prot,
    input  logic              r_valid,
    output logic              r_ready,
    input  logic [data_w-1:0] r_data,
    input  logic [1:0]        r_resp
);

    logic                        hit;
    logic [ways-1:0]             hit_way;
    logic [ways-1:0][data_w-1:0] rd_data;
    logic [ways-1:0]             victim;
    logic [index_w-1:0]          rd_index;
    logic [tag_w-1:0]            rd_tag;
    logic [1:0]                  rd_word;
    logic [ways-1:0]             data_we;
    logic [index_w-1:0]          wr_index;   // also the LRU set
    logic [1:0]                  wr_word;
    logic [data_w-1:0]           wr_data;
    logic [ways-1:0]             tag_we;
    icache_tag_t                 wr_entry;
    logic                        set_inval;
    logic                        lru_touch;
    logic [ways-1:0]             touch_way;
    logic                        refill_start;
    logic [addr_w-1:0]           refill_addr;
    logic                        refill_line;
    logic                        word_valid;
    logic [data_w-1:0]           word_data;
    logic [1:0]                  word_idx;
    logic                        word_err;
    logic                        refill_done;
    logic                        refill_err;

    icache_ctrl i_ctrl (
        .clk, .arst_n, .req_valid, .req_ready, .req, .resp_valid, .resp_ready, .resp,
        .hit, .hit_way, .rd_data, .victim, .rd_index, .rd_tag, .rd_word,
        .data_we, .wr_index, .wr_word, .wr_data, .tag_we, .wr_entry, .set_inval,
        .lru_touch, .touch_way, .refill_start, .refill_addr, .refill_line,
        .word_valid, .word_data, .word_idx, .word_err, .refill_done, .refill_err
    );

    icache_tag_array i_tag_array (
        .clk, .arst_n, .rd_index, .rd_tag, .tag_we, .wr_index, .wr_entry,
        .set_inval, .hit_way, .hit
    );

    icache_data_array i_data_array (
        .clk, .rd_index, .rd_word, .data_we, .wr_index, .wr_word, .wr_data, .rd_data
    );

    icache_lru i_lru (
        .clk,
        .arst_n,
        .index     (wr_index),
        .touch     (lru_touch),
        .touch_way,
        .victim
    );

    icache_refill i_refill (
        .clk, .arst_n, .refill_start, .refill_addr, .refill_line,
        .word_valid, .word_data, .word_idx, .word_err, .refill_done, .refill_err,
        .ar_valid, .ar_ready, .ar_addr, .ar_prot, .r_valid, .r_ready, .r_data, .r_resp
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_icache -f verilog.f -o sim_icache
./obj_dir/sim_icache | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: tb_icache.sv
`timescale 1ns/100ps
module tb_icache import icache_pkg::*; ();

    localparam int clk_period = 4;
    localparam int max_pats   = 64;
    localparam int cols       = 6;              // op addr key data exc ars
    localparam logic [31:0] err_lo = 32'h0000_8000;
    localparam logic [31:0] err_hi = 32'h0000_80ff;

    logic         clk;
    logic         arst_n;
    logic         req_valid;
    logic         req_ready;
    icache_req_t  req;
    logic         resp_valid;
    logic         resp_ready;
    icache_resp_t resp;
    logic         ar_valid;
    logic         ar_ready;
    logic [31:0]  ar_addr;
    logic [2:0]   ar_prot;
    logic         r_valid;
    logic         r_ready;
    logic [31:0]  r_data;
    logic [1:0]   r_resp;

    logic [31:0] pat_mem [max_pats*cols];
    logic [31:0] mem_key    = '0;               // memory returns addr ^ mem_key
    logic        reset_done = 1'b0;
    int unsigned lcg_state  = 18440;
    int          ar_count   = 0;
    int          n_errors   = 0;
    int          n_pats     = 0;

    icache_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;                                     // inputs change away from the edge
    endtask

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    // waits for the response and keeps resp_ready low for a random span
    task automatic collect_resp(output icache_resp_t got);
        icache_resp_t first;
        int unsigned  hold;
        while (!resp_valid) next_cycle();
        first = resp;
        hold  = lcg_next() % 6;
        repeat (hold) begin
            next_cycle();
            check_equal("held response", 64'({resp_valid, resp}), 64'({1'b1, first}));
        end
        resp_ready = 1'b1;
        got        = resp;
        next_cycle();
        resp_ready = 1'b0;
        check_equal("response count", 64'(resp_valid), 64'(0));   // only one per request
    endtask

    // AXI4-Lite read slave, one beat per AR
    initial begin : axi_memory
        logic [31:0] addr;
        int unsigned delay;
        logic        in_err;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        r_resp   = 2'b00;
        wait (reset_done);
        forever begin
            while (!ar_valid) next_cycle();
            delay = lcg_next() % 4;
            repeat (delay) next_cycle();        // address must hold meanwhile
            addr     = ar_addr;
            check_equal("ar_prot", 64'(ar_prot), 64'(3'b100));   // instruction access
            ar_ready = 1'b1;
            next_cycle();
            ar_ready = 1'b0;
            ar_count++;
            delay = lcg_next() % 4;
            repeat (delay) next_cycle();
            in_err  = (addr >= err_lo) && (addr <= err_hi);
            r_valid = 1'b1;
            r_data  = in_err ? '0 : (addr ^ mem_key);
            r_resp  = in_err ? 2'b10 : 2'b00;   // SLVERR
            check_equal("r_ready at the R beat", 64'(r_ready), 64'(1));
            next_cycle();
            r_valid = 1'b0;
            r_resp  = 2'b00;
        end
    end

    initial begin : stimulus
        icache_resp_t got;
        int           cnt;
        int           ars_before;
        int           errs_before;
        int           n_bad;
        n_bad       = 0;
        cnt         = 0;
        ars_before  = 0;
        errs_before = 0;
        arst_n      = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        resp_ready  = 1'b0;
        $readmemh("icache_patterns.txt", pat_mem);
        while (cnt < max_pats && pat_mem[cnt*cols] !== 32'hff
               && !$isunknown(pat_mem[cnt*cols]))
            cnt++;
        n_pats = cnt;
        if (n_pats == 0) begin
            $display("no commands could be read from icache_patterns.txt");
            n_errors++;
        end
        #1 arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        arst_n     = 1'b1;
        reset_done = 1'b1;
        // each command waits at the request port while the one before it finishes
        for (int i = 0; i <= n_pats; i++) begin
            if (i < n_pats) begin
                req.op    = icache_op_e'(pat_mem[i*cols][1:0]);
                req.addr  = pat_mem[i*cols+1];
                req_valid = 1'b1;
            end
            if (i > 0) begin
                collect_resp(got);
                check_equal($sformatf("test %0d data", i - 1), 64'(got.data),
                            64'(pat_mem[(i-1)*cols+3]));
                check_equal($sformatf("test %0d exception", i - 1), 64'(got.exc),
                            64'(pat_mem[(i-1)*cols+4]));
                check_equal($sformatf("test %0d AR count", i - 1),
                            64'(ar_count - ars_before), 64'(pat_mem[(i-1)*cols+5]));
                if (n_errors != errs_before) n_bad++;
                $display("test %0d: op %0d addr %h %s", i - 1, pat_mem[(i-1)*cols][1:0],
                         pat_mem[(i-1)*cols+1], (n_errors == errs_before) ? "ok" : "failed");
            end
            if (i < n_pats) begin
                errs_before = n_errors;
                ars_before  = ar_count;
                mem_key     = pat_mem[i*cols+2];
                while (!req_ready) next_cycle();
                next_cycle();                   // accepted at this edge
                req_valid = 1'b0;
            end
        end
        $display("tests run %0d, tests failed %0d, failed checks %0d", n_pats, n_bad, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // 200 cycles for every command
    initial begin : watchdog
        wait (n_pats != 0);
        #(n_pats * 200 * clk_period);
        $display("timeout: the run did not finish within %0d cycles", n_pats * 200);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: verilog.f
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_lru.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
icache_assertions.sv
tb_icache.sv
